// File: hw/gfx_pkg.sv
// Shared types for the pixel rendering back end
// Vector typedefs for coordinates, addresses, colours, depths and strips
// Colour depth codes and their bits-per-pixel mapping
// State encodings for the renderer and the strip writer
`default_nettype none

package gfx_pkg;

	// Meaningful widths
	typedef logic [15:0]  coord_t;
	typedef logic [31:0]  addr_t;
	typedef logic [31:0]  color_t;
	typedef logic [15:0]  depth_t;
	typedef logic [127:0] strip_t;
	typedef logic [6:0]   bitpos_t;

	// Pixel depth codes, BPP16 doubles as the depth buffer format
	typedef enum logic [2:0] {
		BPP1  = 3'd0,
		BPP2  = 3'd1,
		BPP4  = 3'd2,
		BPP8  = 3'd3,
		BPP12 = 3'd4,
		BPP16 = 3'd5,
		BPP24 = 3'd6,
		BPP32 = 3'd7
	} color_depth_e;

	// Bit count for a depth code
	function automatic logic [5:0] bits_per_pixel(input color_depth_e cd);
		case (cd)
			BPP1:    return 6'd1;
			BPP2:    return 6'd2;
			BPP4:    return 6'd4;
			BPP8:    return 6'd8;
			BPP12:   return 6'd12;
			BPP16:   return 6'd16;
			BPP24:   return 6'd24;
			default: return 6'd32;
		endcase
	endfunction

	// Pixel sequencer states
	typedef enum logic [2:0] {R_IDLE, R_CLIP, R_WRITE_PIXEL, R_WRITE_Z, R_DONE} render_state_e;

	// Read-modify-write states
	typedef enum logic [1:0] {S_IDLE, S_READ, S_WRITE, S_ACK} strip_state_e;

endpackage

`default_nettype wire

// File: hw/gfx_calc_address.sv
// Strip address calculator for one pixel in one buffer
// Linear pixel index from x, y and row width
// Strip number and bit field (mb..me) inside a 128-bit strip
`default_nettype none

module gfx_calc_address #(
	parameter int STRIP_BYTES_LOG2 = 4
) (
	input  wire gfx_pkg::addr_t       base_addr_i,
	input  wire gfx_pkg::color_depth_e color_depth_i,
	input  wire gfx_pkg::coord_t      size_x_i,
	input  wire gfx_pkg::coord_t      x_i,
	input  wire gfx_pkg::coord_t      y_i,
	output gfx_pkg::addr_t            addr_o,
	output gfx_pkg::bitpos_t          mb_o,
	output gfx_pkg::bitpos_t          me_o
);

	gfx_pkg::addr_t pix_index;
	gfx_pkg::addr_t strip_idx;
	logic [6:0]     pix_rem;
	logic [5:0]     bpp;
	logic [12:0]    mb_full;
	logic [12:0]    me_full;

	// Row-major index, full 32 bits so large targets do not wrap
	assign pix_index = gfx_pkg::addr_t'(y_i) * gfx_pkg::addr_t'(size_x_i)
		+ gfx_pkg::addr_t'(x_i);

	assign bpp = gfx_pkg::bits_per_pixel(color_depth_i);

	// Divide by pixels per strip
	always_comb
	begin
		case (color_depth_i)
			// 128 ppstrip
			gfx_pkg::BPP1:  strip_idx = pix_index >> 7;
			// 64
			gfx_pkg::BPP2:  strip_idx = pix_index >> 6;
			gfx_pkg::BPP4:  strip_idx = pix_index >> 5;
			gfx_pkg::BPP8:  strip_idx = pix_index >> 4;
			// 10 pixels, top 8 bits of strip unused
			gfx_pkg::BPP12: strip_idx = pix_index / 10;
			gfx_pkg::BPP16: strip_idx = pix_index >> 3;
			// 5 pixels, top 8 bits unused
			gfx_pkg::BPP24: strip_idx = pix_index / 5;
			default:        strip_idx = pix_index >> 2;
		endcase
	end

	// Pixel slot inside the strip
	always_comb
	begin
		case (color_depth_i)
			gfx_pkg::BPP12: pix_rem = 7'(pix_index - strip_idx * 10);
			gfx_pkg::BPP24: pix_rem = 7'(pix_index - strip_idx * 5);
			// Power-of-two cases, remainder is the dropped low bits
			default:        pix_rem = 7'(pix_index - (strip_idx * 32'(7'd0 + (8'd128 / bpp))));
		endcase
	end

	// Field bounds, kept wide for the range check
	assign mb_full = 13'(pix_rem) * 13'(bpp);
	assign me_full = mb_full + 13'(bpp) - 13'd1;

	assign addr_o = base_addr_i + (strip_idx << STRIP_BYTES_LOG2);
	assign mb_o   = gfx_pkg::bitpos_t'(mb_full);
	assign me_o   = gfx_pkg::bitpos_t'(me_full);

	// Field must stay inside one strip
	a_me_in_strip: assert final ($isunknown(me_full) || me_full <= 13'd127)
		else $error("field end %0d beyond strip", me_full);

endmodule

`default_nettype wire

// File: hw/gfx_renderer.sv
// Pixel sequencer
// Clips against the target size
// Issues the colour field, then the optional depth field
// Raises a single ack per pixel
`default_nettype none

module gfx_renderer (
	input  wire logic             clk_i,
	input  wire logic             rst_i,
	input  wire logic             write_i,
	input  wire logic             zbuffer_enable_i,
	output logic                  ack_o,
	input  wire gfx_pkg::coord_t  pixel_x_i,
	input  wire gfx_pkg::coord_t  pixel_y_i,
	input  wire gfx_pkg::coord_t  size_x_i,
	input  wire gfx_pkg::coord_t  size_y_i,
	input  wire gfx_pkg::color_t  color_i,
	input  wire gfx_pkg::depth_t  pixel_z_i,
	input  wire gfx_pkg::addr_t   target_addr_i,
	input  wire gfx_pkg::bitpos_t target_mb_i,
	input  wire gfx_pkg::bitpos_t target_me_i,
	input  wire gfx_pkg::addr_t   zbuffer_addr_i,
	input  wire gfx_pkg::bitpos_t zbuffer_mb_i,
	input  wire gfx_pkg::bitpos_t zbuffer_me_i,
	output logic                  field_write_o,
	output gfx_pkg::addr_t        field_addr_o,
	output gfx_pkg::color_t       field_dat_o,
	output gfx_pkg::bitpos_t      field_mb_o,
	output gfx_pkg::bitpos_t      field_me_o,
	input  wire logic             field_ack_i
);

	gfx_pkg::render_state_e state;
	logic                   clipped;
	logic                   field_busy;

	// Depth field held until the colour write finishes
	gfx_pkg::addr_t   z_addr_q;
	gfx_pkg::bitpos_t z_mb_q;
	gfx_pkg::bitpos_t z_me_q;
	gfx_pkg::depth_t  z_dat_q;

	// Outside the target in either axis
	assign clipped = (pixel_x_i >= size_x_i) || (pixel_y_i >= size_y_i);

	// One ack cycle per pixel
	assign ack_o = (state == gfx_pkg::R_DONE);

	// Sequencer
	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			state         <= gfx_pkg::R_IDLE;
			field_write_o <= 1'b0;
		end
		else
		begin
			// Request is a pulse
			field_write_o <= 1'b0;
			case (state)
				gfx_pkg::R_IDLE:
					if (write_i)
					begin
						if (clipped)
							state <= gfx_pkg::R_CLIP;
						else
						begin
							field_write_o <= 1'b1;
							state         <= gfx_pkg::R_WRITE_PIXEL;
						end
					end
				// Spacer cycle, keeps clip ack at two cycles
				gfx_pkg::R_CLIP:
					state <= gfx_pkg::R_DONE;
				gfx_pkg::R_WRITE_PIXEL:
					if (field_ack_i)
					begin
						if (zbuffer_enable_i)
						begin
							field_write_o <= 1'b1;
							state         <= gfx_pkg::R_WRITE_Z;
						end
						else
							state <= gfx_pkg::R_DONE;
					end
				gfx_pkg::R_WRITE_Z:
					if (field_ack_i)
						state <= gfx_pkg::R_DONE;
				gfx_pkg::R_DONE:
					state <= gfx_pkg::R_IDLE;
				default:
					state <= gfx_pkg::R_IDLE;
			endcase
		end
	end

	// Field payload
	always_ff @(posedge clk_i)
	begin
		if (state == gfx_pkg::R_IDLE && write_i)
		begin
			// Colour goes out first
			field_addr_o <= target_addr_i;
			field_dat_o  <= color_i;
			field_mb_o   <= target_mb_i;
			field_me_o   <= target_me_i;
			// Pixel inputs may change, so capture depth now
			z_addr_q     <= zbuffer_addr_i;
			z_mb_q       <= zbuffer_mb_i;
			z_me_q       <= zbuffer_me_i;
			z_dat_q      <= pixel_z_i;
		end
		else if (state == gfx_pkg::R_WRITE_PIXEL && field_ack_i)
		begin
			field_addr_o <= z_addr_q;
			// Depth zero-extended, right aligned
			field_dat_o  <= gfx_pkg::color_t'(z_dat_q);
			field_mb_o   <= z_mb_q;
			field_me_o   <= z_me_q;
		end
	end

	// Field issued and not yet acked
	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			field_busy <= 1'b0;
		else if (field_write_o)
			field_busy <= 1'b1;
		else if (field_ack_i)
			field_busy <= 1'b0;
	end

	// Source waits for ack before the next pixel
	a_write_in_idle: assert property (@(posedge clk_i) disable iff (rst_i)
		write_i |-> state == gfx_pkg::R_IDLE);

	// Only one field in flight toward the strip writer
	a_one_field: assert property (@(posedge clk_i) disable iff (rst_i)
		field_write_o |-> !field_busy);

endmodule

`default_nettype wire

// File: hw/gfx_strip_writer.sv
// Read-modify-write engine for one 128-bit strip
// Reads the strip, merges bits mb..me from the field data
// Writes the strip back and acks the field
`default_nettype none

module gfx_strip_writer #(
	parameter int STRIP_BYTES_LOG2 = 4
) (
	input  wire logic             clk_i,
	input  wire logic             rst_i,
	input  wire logic             field_write_i,
	input  wire gfx_pkg::addr_t   field_addr_i,
	input  wire gfx_pkg::color_t  field_dat_i,
	input  wire gfx_pkg::bitpos_t field_mb_i,
	input  wire gfx_pkg::bitpos_t field_me_i,
	output logic                  field_ack_o,
	output gfx_pkg::addr_t        mem_addr_o,
	output logic                  mem_rd_o,
	input  wire gfx_pkg::strip_t  mem_rdat_i,
	output logic                  mem_we_o,
	output gfx_pkg::strip_t       mem_wdat_o,
	input  wire logic             mem_ack_i
);

	gfx_pkg::strip_state_e state;

	// Captured field
	gfx_pkg::addr_t   addr_q;
	gfx_pkg::color_t  dat_q;
	gfx_pkg::bitpos_t mb_q;
	gfx_pkg::bitpos_t me_q;

	logic [7:0]      field_width;
	gfx_pkg::strip_t low_mask;
	gfx_pkg::strip_t field_mask;
	gfx_pkg::strip_t field_bits;

	// Request levels follow the state
	assign mem_rd_o    = (state == gfx_pkg::S_READ);
	assign mem_we_o    = (state == gfx_pkg::S_WRITE);
	assign field_ack_o = (state == gfx_pkg::S_ACK);

	// Strip aligned address
	assign mem_addr_o = {addr_q[31:STRIP_BYTES_LOG2], {STRIP_BYTES_LOG2{1'b0}}};

	// Number of bits replaced, 1..128
	assign field_width = 8'(me_q) - 8'(mb_q) + 8'd1;

	// A full-width field wraps to all ones
	assign low_mask = (gfx_pkg::strip_t'(1) << field_width) - gfx_pkg::strip_t'(1);

	assign field_mask = low_mask << mb_q;
	assign field_bits = (gfx_pkg::strip_t'(dat_q) << mb_q) & field_mask;

	// Control
	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			state <= gfx_pkg::S_IDLE;
		else
		begin
			case (state)
				gfx_pkg::S_IDLE:
					if (field_write_i)
						state <= gfx_pkg::S_READ;
				// Hold read until memory answers
				gfx_pkg::S_READ:
					if (mem_ack_i)
						state <= gfx_pkg::S_WRITE;
				gfx_pkg::S_WRITE:
					if (mem_ack_i)
						state <= gfx_pkg::S_ACK;
				gfx_pkg::S_ACK:
					state <= gfx_pkg::S_IDLE;
				default:
					state <= gfx_pkg::S_IDLE;
			endcase
		end
	end

	// Payload
	always_ff @(posedge clk_i)
	begin
		if (state == gfx_pkg::S_IDLE && field_write_i)
		begin
			addr_q <= field_addr_i;
			dat_q  <= field_dat_i;
			mb_q   <= field_mb_i;
			me_q   <= field_me_i;
		end
		// Merge into the returned strip, neighbours keep their bits
		if (state == gfx_pkg::S_READ && mem_ack_i)
			mem_wdat_o <= (mem_rdat_i & ~field_mask) | field_bits;
	end

	// Memory sees one access type at a time
	a_rd_we_excl: assert property (@(posedge clk_i) disable iff (rst_i)
		!(mem_rd_o && mem_we_o));

endmodule

`default_nettype wire

// File: hw/gfx_render_top.sv
// Pixel rendering back end top level
// Colour and depth address calculators
// Pixel sequencer and strip read-modify-write engine
`default_nettype none

module gfx_render_top #(
	parameter int STRIP_BYTES_LOG2 = 4
) (
	input  wire logic                  clk_i,
	input  wire logic                  rst_i,
	input  wire gfx_pkg::addr_t        target_base_i,
	input  wire gfx_pkg::addr_t        zbuffer_base_i,
	input  wire gfx_pkg::coord_t       target_size_x_i,
	input  wire gfx_pkg::coord_t       target_size_y_i,
	input  wire gfx_pkg::color_depth_e color_depth_i,
	input  wire logic                  zbuffer_enable_i,
	input  wire gfx_pkg::coord_t       pixel_x_i,
	input  wire gfx_pkg::coord_t       pixel_y_i,
	input  wire gfx_pkg::depth_t       pixel_z_i,
	input  wire gfx_pkg::color_t       color_i,
	input  wire logic                  write_i,
	output logic                       ack_o,
	output gfx_pkg::addr_t             mem_addr_o,
	output logic                       mem_rd_o,
	input  wire gfx_pkg::strip_t       mem_rdat_i,
	output logic                       mem_we_o,
	output gfx_pkg::strip_t            mem_wdat_o,
	input  wire logic                  mem_ack_i
);

	// Colour buffer placement
	gfx_pkg::addr_t   target_addr;
	gfx_pkg::bitpos_t target_mb;
	gfx_pkg::bitpos_t target_me;

	// Depth buffer placement
	gfx_pkg::addr_t   zbuffer_addr;
	gfx_pkg::bitpos_t zbuffer_mb;
	gfx_pkg::bitpos_t zbuffer_me;

	// Renderer to strip writer
	logic             field_write;
	gfx_pkg::addr_t   field_addr;
	gfx_pkg::color_t  field_dat;
	gfx_pkg::bitpos_t field_mb;
	gfx_pkg::bitpos_t field_me;
	logic             field_ack;

	gfx_calc_address #(.STRIP_BYTES_LOG2(STRIP_BYTES_LOG2)) i_target_addr (
		.base_addr_i   (target_base_i),
		.color_depth_i (color_depth_i),
		.size_x_i      (target_size_x_i),
		.x_i           (pixel_x_i),
		.y_i           (pixel_y_i),
		.addr_o        (target_addr),
		.mb_o          (target_mb),
		.me_o          (target_me)
	);

	// Depth is always 16 bits per pixel
	gfx_calc_address #(.STRIP_BYTES_LOG2(STRIP_BYTES_LOG2)) i_zbuffer_addr (
		.base_addr_i   (zbuffer_base_i),
		.color_depth_i (gfx_pkg::BPP16),
		.size_x_i      (target_size_x_i),
		.x_i           (pixel_x_i),
		.y_i           (pixel_y_i),
		.addr_o        (zbuffer_addr),
		.mb_o          (zbuffer_mb),
		.me_o          (zbuffer_me)
	);

	gfx_renderer i_renderer (
		.clk_i            (clk_i),
		.rst_i            (rst_i),
		.write_i          (write_i),
		.zbuffer_enable_i (zbuffer_enable_i),
		.ack_o            (ack_o),
		.pixel_x_i        (pixel_x_i),
		.pixel_y_i        (pixel_y_i),
		.size_x_i         (target_size_x_i),
		.size_y_i         (target_size_y_i),
		.color_i          (color_i),
		.pixel_z_i        (pixel_z_i),
		.target_addr_i    (target_addr),
		.target_mb_i      (target_mb),
		.target_me_i      (target_me),
		.zbuffer_addr_i   (zbuffer_addr),
		.zbuffer_mb_i     (zbuffer_mb),
		.zbuffer_me_i     (zbuffer_me),
		.field_write_o    (field_write),
		.field_addr_o     (field_addr),
		.field_dat_o      (field_dat),
		.field_mb_o       (field_mb),
		.field_me_o       (field_me),
		.field_ack_i      (field_ack)
	);

	gfx_strip_writer #(.STRIP_BYTES_LOG2(STRIP_BYTES_LOG2)) i_strip_writer (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.field_write_i (field_write),
		.field_addr_i  (field_addr),
		.field_dat_i   (field_dat),
		.field_mb_i    (field_mb),
		.field_me_i    (field_me),
		.field_ack_o   (field_ack),
		.mem_addr_o    (mem_addr_o),
		.mem_rd_o      (mem_rd_o),
		.mem_rdat_i    (mem_rdat_i),
		.mem_we_o      (mem_we_o),
		.mem_wdat_o    (mem_wdat_o),
		.mem_ack_i     (mem_ack_i)
	);

endmodule

`default_nettype wire

// File: tb/gfx_mem_model.sv
// Behavioural 128-bit strip memory for the testbench
// Window of 4096 strips with an address-derived fill
// Acks each read or write after 1 to 6 random cycles
// Flags any access outside the window
`default_nettype none

module gfx_mem_model (
	input  wire logic            clk_i,
	input  wire logic            rst_i,
	input  wire gfx_pkg::addr_t  addr_i,
	input  wire logic            rd_i,
	output gfx_pkg::strip_t      rdat_o,
	input  wire logic            we_i,
	input  wire gfx_pkg::strip_t wdat_i,
	output logic                 ack_o,
	output logic                 bad_o
);

	// Upper address half of the window
	localparam logic [15:0] WINDOW_HI = 16'h2000;

	// 64 KB of strips
	gfx_pkg::strip_t mem [0:4095];

	logic        busy;
	logic [2:0]  delay;
	logic [11:0] idx;

	assign idx = addr_i[15:4];

	// Hash of the full strip address
	function automatic gfx_pkg::strip_t fill_value(input gfx_pkg::addr_t a);
		logic [31:0] h0;
		logic [31:0] h1;
		logic [31:0] h2;
		logic [31:0] h3;
		h0 = a * 32'h9E37_79B1;
		h1 = (a ^ 32'h5BD1_E995) * 32'h85EB_CA6B;
		h2 = {a[15:0], a[31:16]} * 32'hC2B2_AE35;
		h3 = ~a * 32'h27D4_EB2F;
		return {h3 ^ (h0 >> 13), h2 ^ (h1 >> 7), h1, h0 ^ 32'hA5A5_5A5A};
	endfunction

	initial
	begin
		for (int i = 0; i < 4096; i++)
			mem[i] = fill_value({WINDOW_HI, 12'(i), 4'h0});
	end

	always @(posedge clk_i)
	begin
		if (rst_i)
		begin
			busy  <= 1'b0;
			delay <= 3'd0;
			ack_o <= 1'b0;
			bad_o <= 1'b0;
		end
		else
		begin
			ack_o <= 1'b0;
			// New request, skip the cycle of the previous ack
			if (!busy && !ack_o && (rd_i || we_i))
			begin
				busy  <= 1'b1;
				delay <= 3'($urandom % 6);
				if (addr_i[31:16] != WINDOW_HI)
					bad_o <= 1'b1;
			end
			else if (busy)
			begin
				if (delay == 3'd0)
				begin
					busy  <= 1'b0;
					ack_o <= 1'b1;
					// Read data valid in the ack cycle
					if (we_i)
						mem[idx] <= wdat_i;
					else
						rdat_o <= mem[idx];
				end
				else
					delay <= delay - 3'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb/gfx_render_tb.sv
// Testbench for the pixel rendering back end
// Random pixels at every colour depth, with and without depth writes
// Clipped pixels and a back-to-back stream of 200 pixels
// Reference strip memory with its own placement and merge rules
`default_nettype none

module gfx_render_tb;

	localparam int TIMEOUT = 200;
	localparam int STRIPS  = 4096;

	logic                  clk_i;
	logic                  rst_i;
	gfx_pkg::addr_t        target_base_i;
	gfx_pkg::addr_t        zbuffer_base_i;
	gfx_pkg::coord_t       target_size_x_i;
	gfx_pkg::coord_t       target_size_y_i;
	gfx_pkg::color_depth_e color_depth_i;
	logic                  zbuffer_enable_i;
	gfx_pkg::coord_t       pixel_x_i;
	gfx_pkg::coord_t       pixel_y_i;
	gfx_pkg::depth_t       pixel_z_i;
	gfx_pkg::color_t       color_i;
	logic                  write_i;
	logic                  ack_o;
	gfx_pkg::addr_t        mem_addr_o;
	logic                  mem_rd_o;
	gfx_pkg::strip_t       mem_rdat_i;
	logic                  mem_we_o;
	gfx_pkg::strip_t       mem_wdat_o;
	logic                  mem_ack_i;
	logic                  mem_bad;

	// Reference copy of the strip memory
	gfx_pkg::strip_t ref_mem [0:STRIPS-1];

	// Current target settings
	gfx_pkg::color_depth_e cd;
	bit                    zen;
	gfx_pkg::coord_t       size_x;
	gfx_pkg::coord_t       size_y;
	gfx_pkg::addr_t        tbase;
	gfx_pkg::addr_t        zbase;

	int ack_count;
	int traffic_count;
	int checks;
	int errors;
	int test_checks;
	int test_errors;
	int seed;

	gfx_render_top #(.STRIP_BYTES_LOG2(4)) i_gfx_render_top (
		.clk_i            (clk_i),
		.rst_i            (rst_i),
		.target_base_i    (target_base_i),
		.zbuffer_base_i   (zbuffer_base_i),
		.target_size_x_i  (target_size_x_i),
		.target_size_y_i  (target_size_y_i),
		.color_depth_i    (color_depth_i),
		.zbuffer_enable_i (zbuffer_enable_i),
		.pixel_x_i        (pixel_x_i),
		.pixel_y_i        (pixel_y_i),
		.pixel_z_i        (pixel_z_i),
		.color_i          (color_i),
		.write_i          (write_i),
		.ack_o            (ack_o),
		.mem_addr_o       (mem_addr_o),
		.mem_rd_o         (mem_rd_o),
		.mem_rdat_i       (mem_rdat_i),
		.mem_we_o         (mem_we_o),
		.mem_wdat_o       (mem_wdat_o),
		.mem_ack_i        (mem_ack_i)
	);

	gfx_mem_model i_mem_model (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.addr_i (mem_addr_o),
		.rd_i   (mem_rd_o),
		.rdat_o (mem_rdat_i),
		.we_i   (mem_we_o),
		.wdat_i (mem_wdat_o),
		.ack_o  (mem_ack_i),
		.bad_o  (mem_bad)
	);

	always #10 clk_i = ~clk_i;

	// Pulse counters, sampled mid-cycle
	always @(negedge clk_i)
	begin
		if (!rst_i && ack_o)
			ack_count++;
		if (!rst_i && (mem_rd_o || mem_we_o))
			traffic_count++;
	end

	task automatic check_strip(input gfx_pkg::addr_t addr, input gfx_pkg::strip_t got,
		input gfx_pkg::strip_t exp);
		test_checks++;
		if (got !== exp)
		begin
			test_errors++;
			$display("Error mem_strip addr 0x%08h got 0x%032h exp 0x%032h", addr, got, exp);
		end
	endtask

	// One ack pulse per pixel
	task automatic check_ack(input int pulses);
		test_checks++;
		if (pulses != 1)
		begin
			test_errors++;
			$display("Error ack_o pulses got 0x%0h exp 0x1", pulses);
		end
	endtask

	task automatic check_cycles(input string name, input int got, input int exp);
		test_checks++;
		if (got != exp)
		begin
			test_errors++;
			$display("Error %s got 0x%0h exp 0x%0h", name, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		$display("test %-12s checks %0d errors %0d", name, test_checks, test_errors);
		checks      += test_checks;
		errors      += test_errors;
		test_checks  = 0;
		test_errors  = 0;
	endtask

	task automatic finish_run;
		$display("total checks %0d errors %0d", checks + test_checks, errors + test_errors);
		if (errors + test_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	endtask

	// Pixel width for each depth code
	function automatic int pixel_bits(input gfx_pkg::color_depth_e code);
		int table_bits [8];
		table_bits = '{1, 2, 4, 8, 12, 16, 24, 32};
		return table_bits[int'(code)];
	endfunction

	// Strip address and bit field of one pixel
	task automatic place_field(input gfx_pkg::addr_t base, input gfx_pkg::color_depth_e code,
		input gfx_pkg::coord_t x, input gfx_pkg::coord_t y,
		output gfx_pkg::addr_t addr, output int mb, output int me);
		int bpp;
		int per_strip;
		int index;
		bpp       = pixel_bits(code);
		per_strip = 128 / bpp;
		index     = int'(y) * int'(size_x) + int'(x);
		addr      = base + gfx_pkg::addr_t'((index / per_strip) * 16);
		mb        = (index % per_strip) * bpp;
		me        = mb + bpp - 1;
	endtask

	// Low bits of the data replace mb..me
	function automatic gfx_pkg::strip_t merge_field(input gfx_pkg::strip_t old,
		input gfx_pkg::color_t dat, input int mb, input int me);
		gfx_pkg::strip_t s;
		s = old;
		for (int b = mb; b <= me; b++)
			s[b] = dat[b - mb];
		return s;
	endfunction

	task automatic set_target(input gfx_pkg::color_depth_e code, input bit z_on);
		cd     = code;
		zen    = z_on;
		size_x = gfx_pkg::coord_t'(1 + $urandom % 64);
		size_y = gfx_pkg::coord_t'(1 + $urandom % 64);
		// Colour below 0x2000_8000, depth above
		tbase  = 32'h2000_0000 + ($urandom % 512) * 16;
		zbase  = 32'h2000_8000 + ($urandom % 512) * 16;
		color_depth_i    <= cd;
		zbuffer_enable_i <= zen;
		target_size_x_i  <= size_x;
		target_size_y_i  <= size_y;
		target_base_i    <= tbase;
		zbuffer_base_i   <= zbase;
	endtask

	task automatic random_pixel(input bit outside, output gfx_pkg::coord_t x,
		output gfx_pkg::coord_t y);
		x = gfx_pkg::coord_t'($urandom % size_x);
		y = gfx_pkg::coord_t'($urandom % size_y);
		if (outside)
		begin
			// One axis past the edge
			if ($urandom % 2)
				x = gfx_pkg::coord_t'(size_x + $urandom % (32'd65536 - size_x));
			else
				y = gfx_pkg::coord_t'(size_y + $urandom % (32'd65536 - size_y));
		end
	endtask

	// Called just after a rising edge
	task automatic run_pixel(input gfx_pkg::coord_t x, input gfx_pkg::coord_t y);
		gfx_pkg::color_t color;
		gfx_pkg::depth_t z;
		gfx_pkg::addr_t  c_addr;
		gfx_pkg::addr_t  z_addr;
		int              c_mb;
		int              c_me;
		int              z_mb;
		int              z_me;
		int              ack_start;
		int              traffic_start;
		int              cycles;
		bit              clipped;
		bit              seen;
		color   = $urandom;
		z       = gfx_pkg::depth_t'($urandom);
		clipped = (x >= size_x) || (y >= size_y);
		if (!clipped)
		begin
			place_field(tbase, cd, x, y, c_addr, c_mb, c_me);
			ref_mem[c_addr[15:4]] = merge_field(ref_mem[c_addr[15:4]], color, c_mb, c_me);
			// Depth placement always 16 bits
			place_field(zbase, gfx_pkg::BPP16, x, y, z_addr, z_mb, z_me);
			if (zen)
				ref_mem[z_addr[15:4]] = merge_field(ref_mem[z_addr[15:4]],
					gfx_pkg::color_t'(z), z_mb, z_me);
		end
		ack_start     = ack_count;
		traffic_start = traffic_count;
		pixel_x_i <= x;
		pixel_y_i <= y;
		color_i   <= color;
		pixel_z_i <= z;
		write_i   <= 1'b1;
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < TIMEOUT)
		begin
			@(negedge clk_i);
			// A high ack in the write cycle belongs to the previous pixel
			seen = ack_o && (cycles > 0);
			@(posedge clk_i);
			if (cycles == 0)
				write_i <= 1'b0;
			cycles++;
		end
		if (!seen)
		begin
			$display("Timeout waiting for ack_o on pixel x %0d y %0d", x, y);
			test_errors++;
			finish_run();
		end
		else
		begin
			check_ack(ack_count - ack_start);
			if (clipped)
			begin
				// Cycles counted from the write cycle to the ack cycle
				check_cycles("ack_latency", cycles - 1, 2);
				check_cycles("mem_traffic", traffic_count - traffic_start, 0);
			end
			else
			begin
				check_strip(c_addr, i_mem_model.mem[c_addr[15:4]], ref_mem[c_addr[15:4]]);
				check_strip(z_addr, i_mem_model.mem[z_addr[15:4]], ref_mem[z_addr[15:4]]);
			end
		end
	endtask

	initial
	begin
		gfx_pkg::coord_t x;
		gfx_pkg::coord_t y;
		int              stream_start;
		seed             = $urandom(74636);
		clk_i            = 1'b0;
		rst_i            = 1'b1;
		write_i          = 1'b0;
		pixel_x_i        = '0;
		pixel_y_i        = '0;
		pixel_z_i        = '0;
		color_i          = '0;
		target_base_i    = 32'h2000_0000;
		zbuffer_base_i   = 32'h2000_8000;
		target_size_x_i  = 16'd1;
		target_size_y_i  = 16'd1;
		color_depth_i    = gfx_pkg::BPP1;
		zbuffer_enable_i = 1'b0;
		ack_count        = 0;
		traffic_count    = 0;
		checks           = 0;
		errors           = 0;
		test_checks      = 0;
		test_errors      = 0;
		repeat (2) @(posedge clk_i);
		rst_i <= 1'b0;
		// Reference starts from the fill pattern
		for (int i = 0; i < STRIPS; i++)
			ref_mem[i] = i_mem_model.mem[i];

		// Quiet after reset
		repeat (8) @(posedge clk_i);
		check_cycles("idle_ack", ack_count, 0);
		check_cycles("idle_traffic", traffic_count, 0);
		end_test("reset_idle");

		// Colour only, every depth code
		for (int d = 0; d < 8; d++)
		begin
			set_target(gfx_pkg::color_depth_e'(d), 1'b0);
			for (int n = 0; n < 12; n++)
			begin
				random_pixel(1'b0, x, y);
				run_pixel(x, y);
			end
			end_test($sformatf("color_cd%0d", d));
		end

		// Colour plus depth
		for (int n = 0; n < 40; n++)
		begin
			if (n % 10 == 0)
				set_target(gfx_pkg::color_depth_e'($urandom % 8), 1'b1);
			random_pixel(1'b0, x, y);
			run_pixel(x, y);
		end
		end_test("depth_on");

		// Outside the target
		for (int n = 0; n < 30; n++)
		begin
			if (n % 10 == 0)
				set_target(gfx_pkg::color_depth_e'($urandom % 8), 1'($urandom % 2));
			random_pixel(1'b1, x, y);
			run_pixel(x, y);
		end
		end_test("clip");

		// Back-to-back stream, one in ten clipped
		stream_start = ack_count;
		for (int n = 0; n < 200; n++)
		begin
			if (n % 50 == 0)
				set_target(gfx_pkg::color_depth_e'($urandom % 8), 1'($urandom % 2));
			random_pixel($urandom % 10 == 0, x, y);
			run_pixel(x, y);
		end
		// Room for a stray ack
		repeat (4) @(posedge clk_i);
		check_cycles("stream_acks", ack_count - stream_start, 200);
		for (int i = 0; i < STRIPS; i++)
			check_strip({16'h2000, 12'(i), 4'h0}, i_mem_model.mem[i], ref_mem[i]);
		test_checks++;
		if (mem_bad)
		begin
			test_errors++;
			$display("Memory was accessed outside the strip window");
		end
		end_test("stream");
		finish_run();
	end

endmodule

`default_nettype wire

// File: verilog.f
hw/gfx_pkg.sv
hw/gfx_calc_address.sv
hw/gfx_renderer.sv
hw/gfx_strip_writer.sv
hw/gfx_render_top.sv
tb/gfx_mem_model.sv
tb/gfx_render_tb.sv
